// File: design/imuldiv_consts.svh
// operand width and iteration count for the multiply/divide unit
// only a 32-bit datapath with one step per result bit is supported

`ifndef IMULDIV_CONSTS_SVH
`define IMULDIV_CONSTS_SVH

// ------------------------------------------------------------
// datapath sizing
// ------------------------------------------------------------

// operand width, results are twice this wide
`define IMULDIV_XLEN 32

// iteration cycles per operation, one bit per step
`define IMULDIV_STEPS 32

`endif

// File: design/imuldiv_pkg.sv
// shared types for the multiply/divide unit
// opcode 2'd3 is not defined and is never accepted by the top level

`include "imuldiv_consts.svh"

package imuldiv_pkg;

  // operation select carried with every request
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } muldiv_op_e;

  // request payload, op sits in the top bits
  typedef struct packed {
    muldiv_op_e                op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } muldiv_req_t;

  // response payload
  // mul gives the full product
  // div gives remainder in the upper half and quotient in the lower half
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } muldiv_resp_t;

  // iterative engine control states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } engine_state_e;

endpackage

// File: design/imuldiv_mul_iterative.sv
// iterative signed multiplier, 32 shift-add steps on operand magnitudes
// one operation at a time, result held until the response handshake

`timescale 1ns/10ps

`include "imuldiv_consts.svh"

module imuldiv_mul_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`IMULDIV_XLEN-1:0]  req_a,
  input  logic [`IMULDIV_XLEN-1:0]  req_b,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  logic                       load;
  logic                       step;
  logic [2*`IMULDIV_XLEN-1:0] dp_result;

  // shift registers and accumulator
  imuldiv_mul_dpath dpath (
    .clk    (clk),
    .reset  (reset),
    .req_a  (req_a),
    .req_b  (req_b),
    .load   (load),
    .step   (step),
    .result (dp_result)
  );

  // sequencing of load and the 32 steps
  imuldiv_mul_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  assign resp.result = dp_result;

endmodule

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

module imuldiv_mul_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  input  logic                       load,
  input  logic                       step,
  output logic [2*`IMULDIV_XLEN-1:0] result
);

  localparam int W = `IMULDIV_XLEN;

  logic [2*W-1:0] mcand;   // multiplicand, shifts left
  logic [W-1:0]   mplier;  // multiplier, shifts right
  logic [2*W-1:0] acc;
  logic           neg;
  logic [W-1:0]   mag_a;
  logic [W-1:0]   mag_b;

  // operand magnitudes, signed minimum maps to 2**31
  assign mag_a = req_a[W-1] ? (~req_a + 1'b1) : req_a;
  assign mag_b = req_b[W-1] ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{W{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (load) begin
      acc <= '0;
      // product sign is the xor of operand signs
      neg <= req_a[W-1] ^ req_b[W-1];
    end else if (step && mplier[0]) begin
      acc <= acc + mcand;
    end
  end

  // sign fix on the way out
  assign result = neg ? (~acc + 1'b1) : acc;

endmodule

// ------------------------------------------------------------
// control
// ------------------------------------------------------------

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  import imuldiv_pkg::*;

  localparam int CNT_W = $clog2(`IMULDIV_STEPS);

  engine_state_e    state;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (load) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // last step lands on the final count value
          if (count == CNT_W'(`IMULDIV_STEPS - 1)) begin
            state <= ST_DONE;
          end
          count <= count + 1'b1;
        end
        ST_DONE: begin
          if (resp_rdy) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign req_rdy  = (state == ST_IDLE);
  assign load     = req_val && req_rdy;
  assign step     = (state == ST_CALC);
  assign resp_val = (state == ST_DONE);

endmodule

// File: design/imuldiv_div_iterative.sv
// iterative restoring divider, signed or unsigned per request
// divide by zero is not trapped, quotient magnitude is all ones

`timescale 1ns/10ps

`include "imuldiv_consts.svh"

module imuldiv_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`IMULDIV_XLEN-1:0]  req_a,
  input  logic [`IMULDIV_XLEN-1:0]  req_b,
  input  logic                      req_signed,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  logic                       load;
  logic                       step;
  logic [2*`IMULDIV_XLEN-1:0] dp_result;

  // remainder/quotient register and divisor
  imuldiv_div_dpath dpath (
    .clk        (clk),
    .reset      (reset),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_signed (req_signed),
    .load       (load),
    .step       (step),
    .result     (dp_result)
  );

  imuldiv_div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  assign resp.result = dp_result;

endmodule

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

module imuldiv_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  input  logic                       req_signed,
  input  logic                       load,
  input  logic                       step,
  output logic [2*`IMULDIV_XLEN-1:0] result
);

  localparam int W = `IMULDIV_XLEN;

  logic [2*W-1:0] rq;      // {partial remainder, dividend/quotient}
  logic [W-1:0]   dvs;     // divisor magnitude
  logic           q_neg;
  logic           r_neg;
  logic [W-1:0]   mag_a;
  logic [W-1:0]   mag_b;
  logic [W+1:0]   diff;
  logic [W-1:0]   quo;
  logic [W-1:0]   rem;

  // unsigned requests take the operands as they are
  assign mag_a = (req_signed && req_a[W-1]) ? (~req_a + 1'b1) : req_a;
  assign mag_b = (req_signed && req_b[W-1]) ? (~req_b + 1'b1) : req_b;

  // trial subtract on the shifted remainder
  // the bit shifted out of the top is kept, it matters for divisors above 2**31
  assign diff = {1'b0, rq[2*W-1:W-1]} - {2'b00, dvs};

  always_ff @(posedge clk) begin
    if (reset) begin
      rq <= '0;
    end else if (load) begin
      rq <= {{W{1'b0}}, mag_a};
    end else if (step) begin
      if (!diff[W+1]) begin
        // fits, keep the difference and set the quotient bit
        rq <= {diff[W-1:0], rq[W-2:0], 1'b1};
      end else begin
        // restore, plain shift
        rq <= {rq[2*W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dvs   <= '0;
      q_neg <= 1'b0;
      r_neg <= 1'b0;
    end else if (load) begin
      dvs   <= mag_b;
      // quotient negative when signs differ, remainder follows the dividend
      q_neg <= req_signed && (req_a[W-1] ^ req_b[W-1]);
      r_neg <= req_signed && req_a[W-1];
    end
  end

  assign quo    = q_neg ? (~rq[W-1:0] + 1'b1) : rq[W-1:0];
  assign rem    = r_neg ? (~rq[2*W-1:W] + 1'b1) : rq[2*W-1:W];
  assign result = {rem, quo};

endmodule

// ------------------------------------------------------------
// control
// ------------------------------------------------------------

module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  import imuldiv_pkg::*;

  localparam int CNT_W = $clog2(`IMULDIV_STEPS);

  engine_state_e    state;
  logic [CNT_W-1:0] remaining;  // steps left after this one

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      remaining <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (load) begin
            state     <= ST_CALC;
            remaining <= CNT_W'(`IMULDIV_STEPS - 1);
          end
        end
        ST_CALC: begin
          // counts down, same 32 cycles as the multiplier
          if (remaining == '0) begin
            state <= ST_DONE;
          end else begin
            remaining <= remaining - 1'b1;
          end
        end
        ST_DONE: begin
          if (resp_rdy) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign req_rdy  = (state == ST_IDLE);
  assign load     = req_val && req_rdy;
  assign step     = (state == ST_CALC);
  assign resp_val = (state == ST_DONE);

endmodule

// File: design/imuldiv_unit.sv
// multiply/divide unit, one operation in flight, 33 cycles accept to response
// requests with an undefined opcode are never accepted

`timescale 1ns/10ps

module imuldiv_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  import imuldiv_pkg::*;

  logic         sel_mul;
  logic         sel_div;
  logic         div_signed;
  logic         idle;
  logic         owner_mul;   // multiplier holds the current operation
  logic         owner_div;   // divider holds the current operation
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;
  muldiv_resp_t mul_resp;
  muldiv_resp_t div_resp;
  logic         mul_resp_val;
  logic         div_resp_val;

  // ------------------------------------------------------------
  // opcode decode and dispatch
  // ------------------------------------------------------------

  always_comb begin
    sel_mul    = 1'b0;
    sel_div    = 1'b0;
    div_signed = 1'b0;
    case (req.op)
      OP_MUL:  sel_mul = 1'b1;
      OP_DIV: begin
        sel_div    = 1'b1;
        div_signed = 1'b1;
      end
      OP_DIVU: sel_div = 1'b1;
      default: ;
    endcase
  end

  assign idle        = !owner_mul && !owner_div;
  assign mul_req_val = req_val && idle && sel_mul;
  assign div_req_val = req_val && idle && sel_div;
  assign req_rdy     = idle && ((sel_mul && mul_req_rdy) || (sel_div && div_req_rdy));

  // owner set on accept, cleared when the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      owner_mul <= 1'b0;
      owner_div <= 1'b0;
    end else if (resp_val && resp_rdy) begin
      owner_mul <= 1'b0;
      owner_div <= 1'b0;
    end else begin
      if (mul_req_val && mul_req_rdy) owner_mul <= 1'b1;
      if (div_req_val && div_req_rdy) owner_div <= 1'b1;
    end
  end

  imuldiv_mul_iterative mul_i (
    .clk      (clk),
    .reset    (reset),
    .req_a    (req.a),
    .req_b    (req.b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy && owner_mul)
  );

  imuldiv_div_iterative div_i (
    .clk        (clk),
    .reset      (reset),
    .req_a      (req.a),
    .req_b      (req.b),
    .req_signed (div_signed),
    .req_val    (div_req_val),
    .req_rdy    (div_req_rdy),
    .resp       (div_resp),
    .resp_val   (div_resp_val),
    .resp_rdy   (resp_rdy && owner_div)
  );

  // response comes only from the owner
  assign resp     = owner_mul ? mul_resp : div_resp;
  assign resp_val = (owner_mul && mul_resp_val) || (owner_div && div_resp_val);

endmodule

// File: testbench/imuldiv_unit_tb.sv
// self-checking testbench for the multiply/divide unit
// operands come from a fixed-seed xorshift
// each response is stalled 0 to 10 cycles before it is taken

`timescale 1ns/10ps

`include "imuldiv_consts.svh"

module imuldiv_unit_tb;

  import imuldiv_pkg::*;

  localparam int W       = `IMULDIV_XLEN;
  localparam int LATENCY = `IMULDIV_STEPS + 1;
  localparam int TIMEOUT = 100;

  logic         clk;
  logic         reset;
  muldiv_req_t  req;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp;
  logic         resp_val;
  logic         resp_rdy;

  logic [W-1:0]   rng_state;
  logic [2*W-1:0] expected_q[$];
  int             check_errors;
  int             monitor_errors;
  int             held_errors;
  int             busy_errors;
  int             tests_passed;
  int             tests_failed;

  // latency monitor state
  logic busy;
  logic got_val;
  int   lat;

  imuldiv_unit imuldiv_unit_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // protocol assertions
  // ------------------------------------------------------------

  // a stalled response keeps its valid and its data
  resp_held_a: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp.result)))
  else begin
    held_errors++;
    $display("Fail %0t response dropped or changed while resp_rdy was low", $time);
  end

  // nothing new is accepted while a response waits
  no_accept_a: assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
  else begin
    busy_errors++;
    $display("Fail %0t request side was ready while a response was waiting", $time);
  end

  // latency from the accept edge to the first resp_val
  // req_rdy must stay low until the response transfers
  always @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      got_val <= 1'b0;
      lat     <= 0;
    end else if (busy) begin
      assert (!req_rdy) else begin
        monitor_errors++;
        $display("Fail %0t req_rdy expected %b got %b", $time, 1'b0, req_rdy);
      end
      if (!got_val) begin
        if (resp_val) begin
          assert (lat == LATENCY) else begin
            monitor_errors++;
            $display("Fail %0t resp_val latency expected %0d got %0d", $time, LATENCY, lat);
          end
          got_val <= 1'b1;
        end else begin
          lat <= lat + 1;
        end
      end
      if (resp_val && resp_rdy) busy <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy    <= 1'b1;
      got_val <= 1'b0;
      lat     <= 1;
    end
  end

  // ------------------------------------------------------------
  // stimulus and reference model
  // ------------------------------------------------------------

  function automatic logic [W-1:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // mostly random operands with some corners and some small signed values
  function automatic logic [W-1:0] pick_operand();
    logic [W-1:0] r;
    logic [W-1:0] v;
    r = next_rand();
    v = next_rand();
    if (r[3:0] < 4'd3) begin
      case (v % 5)
        0:       return 32'h0000_0000;
        1:       return 32'h0000_0001;
        2:       return 32'hffff_ffff;
        3:       return 32'h8000_0000;
        default: return 32'h7fff_ffff;
      endcase
    end
    if (r[3:0] < 4'd6) begin
      v = v % 256;
      return r[31] ? -v : v;
    end
    return v;
  endfunction

  // division gives {remainder, quotient}
  // mul gives the full signed product
  function automatic logic [2*W-1:0] expected_result(input muldiv_op_e op,
                                                     input logic [W-1:0] a,
                                                     input logic [W-1:0] b);
    longint       sa;
    longint       sb;
    longint       q;
    longint       r;
    logic [W-1:0] uq;
    logic [W-1:0] ur;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (op == OP_MUL) return sa * sb;
    if (b == '0) begin
      // quotient magnitude is all ones and the remainder is the dividend
      // the quotient sign only flips for a negative signed dividend
      uq = (op == OP_DIV && a[W-1]) ? 32'd1 : 32'hffff_ffff;
      ur = a;
    end else if (op == OP_DIV) begin
      q  = sa / sb;
      r  = sa % sb;
      uq = q[W-1:0];
      ur = r[W-1:0];
    end else begin
      uq = a / b;
      ur = a % b;
    end
    return {ur, uq};
  endfunction

  function automatic int total_errors();
    return check_errors + monitor_errors + held_errors + busy_errors;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
    $display("Result: FAILED");
    $finish;
  endtask

  // hold one request until the accept edge and return just after it
  task automatic send_request(input muldiv_op_e op, input logic [W-1:0] a,
                              input logic [W-1:0] b);
    int   wait_cycles;
    logic ready_seen;
    wait_cycles = 0;
    req.op  = op;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    forever begin
      #1;
      ready_seen = req_rdy;
      @(posedge clk);
      #1;
      if (ready_seen) break;
      wait_cycles++;
      if (wait_cycles > TIMEOUT) stop_on_timeout("req_rdy");
    end
    expected_q.push_back(expected_result(op, a, b));
  endtask

  // kind 0 sends only mul
  // kind 1 sends div and divu with the corner cases first
  // kind 2 alternates mul with div or divu
  task automatic drive_requests(input int kind, input int count);
    muldiv_op_e   op;
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] r;
    for (int i = 0; i < count; i++) begin
      a = pick_operand();
      b = pick_operand();
      r = next_rand();
      case (kind)
        0:       op = OP_MUL;
        1:       op = r[0] ? OP_DIV : OP_DIVU;
        default: op = (i % 2 == 0) ? OP_MUL : (r[0] ? OP_DIV : OP_DIVU);
      endcase
      if (kind == 1 && i < 4) begin
        case (i)
          // signed minimum by -1
          0: begin
            op = OP_DIV;
            a  = 32'h8000_0000;
            b  = 32'hffff_ffff;
          end
          // divide by zero with a negative dividend
          1: begin
            op = OP_DIV;
            a  = 32'hffff_fff9;
            b  = 32'h0;
          end
          2: begin
            op = OP_DIV;
            a  = 32'h0000_0005;
            b  = 32'h0;
          end
          default: begin
            op = OP_DIVU;
            a  = 32'hdead_beef;
            b  = 32'h0;
          end
        endcase
      end
      send_request(op, a, b);
    end
    req_val = 1'b0;
  endtask

  // stall each response before taking it and compare in request order
  task automatic collect_responses(input int count);
    int             wait_cycles;
    int             stall;
    logic [2*W-1:0] got;
    logic [2*W-1:0] expected;
    for (int i = 0; i < count; i++) begin
      wait_cycles = 0;
      resp_rdy    = 1'b0;
      while (!resp_val) begin
        @(posedge clk);
        #1;
        wait_cycles++;
        if (wait_cycles > TIMEOUT) stop_on_timeout("resp_val");
      end
      got   = resp.result;
      stall = int'(next_rand() % 11);
      repeat (stall) begin
        @(posedge clk);
        #1;
      end
      resp_rdy = 1'b1;
      @(posedge clk);
      #1;
      resp_rdy = 1'b0;
      if (expected_q.size() == 0) begin
        check_errors++;
        $display("response at %0t arrived with no request outstanding", $time);
      end else begin
        expected = expected_q.pop_front();
        assert (got === expected) else begin
          check_errors++;
          $display("Fail %0t resp.result expected %h got %h", $time, expected, got);
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (total_errors() == errors_before) begin
      tests_passed++;
      $display("test %s finished, no errors", name);
    end else begin
      tests_failed++;
      $display("test %s finished, %0d errors", name, total_errors() - errors_before);
    end
  endtask

  task automatic run_test(input string name, input int kind, input int count);
    int errors_before;
    errors_before = total_errors();
    fork
      drive_requests(kind, count);
      collect_responses(count);
    join
    report_test(name, errors_before);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    int errors_before;
    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    rng_state = 32'd95316;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    errors_before = total_errors();
    @(posedge clk);
    #1;
    assert (req_rdy === 1'b1) else begin
      check_errors++;
      $display("Fail %0t req_rdy expected %b got %b", $time, 1'b1, req_rdy);
    end
    assert (resp_val === 1'b0) else begin
      check_errors++;
      $display("Fail %0t resp_val expected %b got %b", $time, 1'b0, resp_val);
    end
    report_test("reset_state", errors_before);

    run_test("mul_random", 0, 200);
    run_test("div_random", 1, 200);
    run_test("mul_div_alternating", 2, 40);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+design
design/imuldiv_pkg.sv
design/imuldiv_mul_iterative.sv
design/imuldiv_div_iterative.sv
design/imuldiv_unit.sv
testbench/imuldiv_unit_tb.sv

// File: Makefile
# Verilator build and run for the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= imuldiv_unit_tb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -F -x -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
